//--- hw/usb4_rx_defs.svh
`ifndef USB4_RX_DEFS_SVH
`define USB4_RX_DEFS_SVH

// Width of one encoded block as seen on a lane bus
`define USB4_ENC_W 132

// Sync header widths for 64b/66b and 128b/132b coding
`define USB4_G2_HDR_W 2
`define USB4_G3_HDR_W 4

// Payload bytes carried by one block
`define USB4_G2_BYTES 8
`define USB4_G3_BYTES 16

// First byte of the skew measurement pattern inside an ordered set
`define USB4_OS_MARK 8'hc5

// Largest lane-to-lane byte offset the deskew can take out
`define USB4_MAX_SKEW 3

`endif

//--- hw/usb4_lane_pkg.sv
`default_nettype none

package usb4_lane_pkg;

    // Link speed, any code other than GEN3 is treated as GEN2
    typedef enum logic [1:0] {
        GEN3 = 2'b01,
        GEN2 = 2'b10
    } gen_speed_t;

    // Deskew FSM states
    typedef enum logic [1:0] {
        SEARCH  = 2'b00,
        MEASURE = 2'b01,
        LOCKED  = 2'b10
    } deskew_state_t;

endpackage

`default_nettype wire

//--- hw/usb4_line_code_pkg.sv
`default_nettype none

`include "usb4_rx_defs.svh"

package usb4_line_code_pkg;

    // 64b/66b block in the low 66 bits of the lane word
    typedef struct packed {
        logic [`USB4_ENC_W-`USB4_G2_HDR_W-8*`USB4_G2_BYTES-1:0] unused;
        logic [`USB4_G2_BYTES-1:0][7:0]                          payload;
        logic [`USB4_G2_HDR_W-1:0]                               hdr;
    } g2_block_t;

    // 128b/132b block fills the whole lane word
    typedef struct packed {
        logic [`USB4_G3_BYTES-1:0][7:0] payload;
        logic [`USB4_G3_HDR_W-1:0]      hdr;
    } g3_block_t;

    // Same lane word, read under whichever layout the link speed selects
    typedef union packed {
        g2_block_t g2;
        g3_block_t g3;
    } enc_block_u;

    // Sync header codes
    localparam logic [`USB4_G2_HDR_W-1:0] G2_HDR_OS   = 2'b01;
    localparam logic [`USB4_G2_HDR_W-1:0] G2_HDR_DATA = 2'b10;
    localparam logic [`USB4_G3_HDR_W-1:0] G3_HDR_OS   = 4'b0101;
    localparam logic [`USB4_G3_HDR_W-1:0] G3_HDR_DATA = 4'b1010;

endpackage

`default_nettype wire

//--- hw/rx_lane_if.sv
`timescale 1ns/10ps
`default_nettype none

interface rx_lane_if;

    // One byte per lane per cycle while byte_valid is high
    logic [7:0] lane_0_byte;
    logic [7:0] lane_1_byte;
    logic       byte_valid;

    // Block class from the lane-0 header, and first byte of a block
    logic       data_os;
    logic       block_start;

    modport decoder (
        output lane_0_byte,
        output lane_1_byte,
        output byte_valid,
        output data_os,
        output block_start
    );

    modport deskew (
        input lane_0_byte,
        input lane_1_byte,
        input byte_valid,
        input data_os,
        input block_start
    );

endinterface

`default_nettype wire

//--- hw/rx_block_decoder.sv
`timescale 1ns/10ps
`default_nettype none

`include "usb4_rx_defs.svh"

module rx_block_decoder (
    input  wire                            enc_clk,
    input  wire                            rst,
    input  wire                            enable_dec,
    input  wire usb4_lane_pkg::gen_speed_t gen_speed,
    input  wire [`USB4_ENC_W-1:0]          lane_0_rx_enc,
    input  wire [`USB4_ENC_W-1:0]          lane_1_rx_enc,
    rx_lane_if.decoder                     lane
);

    import usb4_line_code_pkg::*;
    import usb4_lane_pkg::*;

    localparam int CNT_W = $clog2(`USB4_G3_BYTES);

    enc_block_u                blk_0;
    enc_block_u                blk_1;

    // Block period counter
    logic [CNT_W-1:0]          last_idx;
    logic [CNT_W-1:0]          cnt;
    logic                      capture;

    // Captured payload and lane-0 header
    logic [7:0]                buf_0 [`USB4_G3_BYTES];
    logic [7:0]                buf_1 [`USB4_G3_BYTES];
    logic [`USB4_G3_HDR_W-1:0] hdr_q;
    logic                      g3_q;

    // Byte read-out of the captured block
    logic                      act;
    logic [CNT_W-1:0]          rd_idx;
    logic [CNT_W-1:0]          rd_last;
    logic                      hdr_os;
    logic                      hdr_data;

    assign blk_0 = lane_0_rx_enc;
    assign blk_1 = lane_1_rx_enc;

    assign last_idx = (gen_speed == GEN3) ? CNT_W'(`USB4_G3_BYTES - 1)
                                          : CNT_W'(`USB4_G2_BYTES - 1);

    // Read-out length follows the speed the block was captured at
    assign rd_last = g3_q ? CNT_W'(`USB4_G3_BYTES - 1)
                          : CNT_W'(`USB4_G2_BYTES - 1);

    // The >= also covers the reset value of the counter at Gen2
    assign capture = enable_dec && (cnt >= last_idx);

    always_comb begin
        if (g3_q) begin
            hdr_os   = (hdr_q == G3_HDR_OS);
            hdr_data = (hdr_q == G3_HDR_DATA);
        end else begin
            hdr_os   = (hdr_q[`USB4_G2_HDR_W-1:0] == G2_HDR_OS);
            hdr_data = (hdr_q[`USB4_G2_HDR_W-1:0] == G2_HDR_DATA);
        end
    end

    // Counter parks on the last byte index while the decoder is disabled
    always_ff @(posedge enc_clk or negedge rst) begin
        if (!rst) begin
            cnt <= '1;
        end else if (!enable_dec) begin
            cnt <= last_idx;
        end else if (cnt >= last_idx) begin
            cnt <= '0;
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

    // Capture both lanes and shift bytes out, one per lane per cycle
    always_ff @(posedge enc_clk) begin
        if (capture) begin
            if (gen_speed == GEN3) begin
                for (int i = 0; i < `USB4_G3_BYTES; i++) begin
                    buf_0[i] <= blk_0.g3.payload[i];
                    buf_1[i] <= blk_1.g3.payload[i];
                end
                hdr_q <= blk_0.g3.hdr;
            end else begin
                for (int i = 0; i < `USB4_G2_BYTES; i++) begin
                    buf_0[i] <= blk_0.g2.payload[i];
                    buf_1[i] <= blk_1.g2.payload[i];
                end
                hdr_q <= {{(`USB4_G3_HDR_W - `USB4_G2_HDR_W){1'b0}}, blk_0.g2.hdr};
            end
        end

        if (act) begin
            lane.lane_0_byte <= buf_0[rd_idx];
            lane.lane_1_byte <= buf_1[rd_idx];
        end
    end

    always_ff @(posedge enc_clk or negedge rst) begin
        if (!rst) begin
            act               <= 1'b0;
            rd_idx            <= '0;
            g3_q              <= 1'b0;
            lane.byte_valid   <= 1'b0;
            lane.block_start  <= 1'b0;
            lane.data_os      <= 1'b0;
        end else begin
            lane.byte_valid  <= act;
            lane.block_start <= act && (rd_idx == '0);

            // Class is taken once per block, an unknown header keeps the old one
            if (act && (rd_idx == '0)) begin
                if (hdr_os) begin
                    lane.data_os <= 1'b1;
                end else if (hdr_data) begin
                    lane.data_os <= 1'b0;
                end
            end

            // A new capture lands on the last byte of the previous block
            if (capture) begin
                act    <= 1'b1;
                rd_idx <= '0;
                g3_q   <= (gen_speed == GEN3);
            end else if (act && (rd_idx != rd_last)) begin
                rd_idx <= rd_idx + 1'b1;
            end else begin
                act <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/lane_deskew.sv
`timescale 1ns/10ps
`default_nettype none

`include "usb4_rx_defs.svh"

module lane_deskew (
    input  wire        enc_clk,
    input  wire        rst,
    rx_lane_if.deskew  lane,
    output logic [7:0] rx_lane_0,
    output logic [7:0] rx_lane_1,
    output logic       rx_valid,
    output logic       rx_os,
    output logic       deskew_locked,
    output logic       skew_error
);

    import usb4_lane_pkg::*;

    localparam int DLY_W  = $clog2(`USB4_MAX_SKEW + 1);
    localparam int IDLE_W = $clog2(`USB4_G3_BYTES);

    deskew_state_t                  state;

    // Delay lines, tap 0 is the undelayed input
    logic [`USB4_MAX_SKEW-1:0][7:0] hist_0;
    logic [`USB4_MAX_SKEW-1:0][7:0] hist_1;
    logic [`USB4_MAX_SKEW-1:0][2:0] hist_c;
    logic [`USB4_MAX_SKEW:0][7:0]   tap_0;
    logic [`USB4_MAX_SKEW:0][7:0]   tap_1;
    logic [`USB4_MAX_SKEW:0][2:0]   tap_c;
    logic [2:0]                     ctl_in;
    logic [2:0]                     ctl_sel;

    // Programmed lane delays and mark offset measurement
    logic [DLY_W-1:0]               dly_0;
    logic [DLY_W-1:0]               dly_1;
    logic [DLY_W-1:0]               off;
    logic                           seen;
    logic                           first_l1;
    logic                           mark_0;
    logic                           mark_1;
    logic                           meas_en;

    logic [IDLE_W-1:0]              idle_cnt;
    logic                           emit;
    logic                           emit_nxt;

    // Control word is {valid, os, start}
    assign ctl_in = {lane.byte_valid, lane.data_os, lane.block_start};

    assign tap_0 = {hist_0, lane.lane_0_byte};
    assign tap_1 = {hist_1, lane.lane_1_byte};
    assign tap_c = {hist_c, ctl_in};

    // Valid, class and block start follow the lane-0 timing
    assign ctl_sel = tap_c[dly_0];

    assign mark_0 = (lane.lane_0_byte == `USB4_OS_MARK);
    assign mark_1 = (lane.lane_1_byte == `USB4_OS_MARK);

    // Bytes that belong to an ordered set under measurement
    assign meas_en = lane.byte_valid &&
                     (((state == SEARCH) && lane.block_start && lane.data_os) ||
                      ((state == MEASURE) && (seen || !lane.block_start || lane.data_os)));

    // Output starts on the first aligned block boundary after lock
    assign emit_nxt = (state == LOCKED) && (emit || (ctl_sel[2] && ctl_sel[0]));

    assign deskew_locked = (state == LOCKED);

    always_ff @(posedge enc_clk) begin
        hist_0    <= tap_0[`USB4_MAX_SKEW-1:0];
        hist_1    <= tap_1[`USB4_MAX_SKEW-1:0];
        rx_lane_0 <= tap_0[dly_0];
        rx_lane_1 <= tap_1[dly_1];
    end

    always_ff @(posedge enc_clk or negedge rst) begin
        if (!rst) begin
            state      <= SEARCH;
            hist_c     <= '0;
            dly_0      <= '0;
            dly_1      <= '0;
            off        <= '0;
            seen       <= 1'b0;
            first_l1   <= 1'b0;
            idle_cnt   <= '0;
            emit       <= 1'b0;
            rx_valid   <= 1'b0;
            rx_os      <= 1'b0;
            skew_error <= 1'b0;
        end else begin
            hist_c     <= tap_c[`USB4_MAX_SKEW-1:0];
            skew_error <= 1'b0;
            emit       <= emit_nxt;
            rx_valid   <= emit_nxt && ctl_sel[2];
            if (emit_nxt && ctl_sel[2]) begin
                rx_os <= ctl_sel[1];
            end

            case (state)
                SEARCH, MEASURE: begin
                    if (!meas_en) begin
                        state <= SEARCH;
                        seen  <= 1'b0;
                    end else if (!seen) begin
                        state <= MEASURE;
                        if (mark_0 && mark_1) begin
                            // Lanes already aligned
                            dly_0 <= '0;
                            dly_1 <= '0;
                            state <= LOCKED;
                        end else if (mark_0 || mark_1) begin
                            seen     <= 1'b1;
                            first_l1 <= mark_1;
                            off      <= DLY_W'(1);
                        end
                    end else if (first_l1 ? mark_0 : mark_1) begin
                        // Hold back whichever lane saw the mark first
                        dly_0 <= first_l1 ? '0 : off;
                        dly_1 <= first_l1 ? off : '0;
                        seen  <= 1'b0;
                        state <= LOCKED;
                    end else if (off == DLY_W'(`USB4_MAX_SKEW)) begin
                        skew_error <= 1'b1;
                        seen       <= 1'b0;
                        state      <= SEARCH;
                    end else begin
                        off <= off + 1'b1;
                    end
                end

                LOCKED: begin
                    // A whole idle block means the decoder was disabled
                    if (lane.byte_valid) begin
                        idle_cnt <= '0;
                    end else if (idle_cnt == IDLE_W'(`USB4_G3_BYTES - 1)) begin
                        idle_cnt <= '0;
                        state    <= SEARCH;
                    end else begin
                        idle_cnt <= idle_cnt + 1'b1;
                    end
                end

                default: begin
                    state <= SEARCH;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- hw/usb4_rx_top.sv
`timescale 1ns/10ps
`default_nettype none

`include "usb4_rx_defs.svh"

module usb4_rx_top (
    input  wire                   enc_clk,
    input  wire                   rst,
    input  wire                   enable_dec,
    input  wire [1:0]             gen_speed,
    input  wire [`USB4_ENC_W-1:0] lane_0_rx_enc,
    input  wire [`USB4_ENC_W-1:0] lane_1_rx_enc,
    output wire [7:0]             rx_lane_0,
    output wire [7:0]             rx_lane_1,
    output wire                   rx_valid,
    output wire                   rx_os,
    output wire                   deskew_locked,
    output wire                   skew_error
);

    import usb4_lane_pkg::*;

    // Decoded byte stream between decoder and deskew
    rx_lane_if u_rx_lane_if ();

    rx_block_decoder u_rx_block_decoder (
        .enc_clk       (enc_clk),
        .rst           (rst),
        .enable_dec    (enable_dec),
        .gen_speed     (gen_speed_t'(gen_speed)),
        .lane_0_rx_enc (lane_0_rx_enc),
        .lane_1_rx_enc (lane_1_rx_enc),
        .lane          (u_rx_lane_if.decoder)
    );

    lane_deskew u_lane_deskew (
        .enc_clk       (enc_clk),
        .rst           (rst),
        .lane          (u_rx_lane_if.deskew),
        .rx_lane_0     (rx_lane_0),
        .rx_lane_1     (rx_lane_1),
        .rx_valid      (rx_valid),
        .rx_os         (rx_os),
        .deskew_locked (deskew_locked),
        .skew_error    (skew_error)
    );

endmodule

`default_nettype wire

//--- sim/tb_usb4_rx.sv
`timescale 1ns/10ps
`default_nettype none

`include "usb4_rx_defs.svh"

module tb_usb4_rx;

    import usb4_lane_pkg::*;
    import usb4_line_code_pkg::*;

    localparam int NUM_CASES = 9;
    localparam int MAX_BLKS  = 8;
    localparam int MAX_BYTES = MAX_BLKS * `USB4_G3_BYTES;

    // Block header codes in the case table with two bits per block
    // Any other code gives an invalid header
    localparam logic [1:0] H_OS   = 2'd0;
    localparam logic [1:0] H_DATA = 2'd1;

    typedef struct packed {
        logic [1:0]  speed;
        logic [3:0]  n_blocks;
        logic [15:0] hdr_pat;
        logic [3:0]  skew;
        logic        exp_lock;
    } case_t;

    logic                   enc_clk;
    logic                   rst;
    logic                   enable_dec;
    logic [1:0]             gen_speed;
    logic [`USB4_ENC_W-1:0] lane_0_rx_enc;
    logic [`USB4_ENC_W-1:0] lane_1_rx_enc;
    wire  [7:0]             rx_lane_0;
    wire  [7:0]             rx_lane_1;
    wire                    rx_valid;
    wire                    rx_os;
    wire                    deskew_locked;
    wire                    skew_error;

    logic [31:0]            lfsr;
    int                     err_cnt;
    int                     case_idx;
    int                     pair_idx;
    logic                   saw_lock;
    logic                   saw_err;

    // Expected output pairs
    logic [7:0]             exp_0 [$];
    logic [7:0]             exp_1 [$];
    // Lane 1 is only checked where it carries real data
    logic                   exp_1_chk [$];
    logic                   exp_os [$];

    usb4_rx_top u_usb4_rx_top (
        .enc_clk       (enc_clk),
        .rst           (rst),
        .enable_dec    (enable_dec),
        .gen_speed     (gen_speed),
        .lane_0_rx_enc (lane_0_rx_enc),
        .lane_1_rx_enc (lane_1_rx_enc),
        .rx_lane_0     (rx_lane_0),
        .rx_lane_1     (rx_lane_1),
        .rx_valid      (rx_valid),
        .rx_os         (rx_os),
        .deskew_locked (deskew_locked),
        .skew_error    (skew_error)
    );

    always #10 enc_clk = ~enc_clk;

    // Columns are speed, blocks, header codes per block, lane-1 skew, lock expected
    function automatic case_t case_row(input int idx);
        case (idx)
            0:       case_row = {GEN2, 4'd4, 16'h0044, 4'd0, 1'b1};
            1:       case_row = {GEN3, 4'd4, 16'h0018, 4'd0, 1'b1};
            2:       case_row = {GEN2, 4'd4, 16'h0094, 4'd1, 1'b1};
            3:       case_row = {GEN3, 4'd3, 16'h0014, 4'd2, 1'b1};
            4:       case_row = {GEN2, 4'd5, 16'h0144, 4'd3, 1'b1};
            5:       case_row = {GEN3, 4'd3, 16'h0014, 4'd3, 1'b1};
            6:       case_row = {GEN2, 4'd3, 16'h0014, 4'd4, 1'b0};
            7:       case_row = {GEN3, 4'd3, 16'h0014, 4'd5, 1'b0};
            default: case_row = {GEN2, 4'd3, 16'h0024, 4'd1, 1'b1};
        endcase
    endfunction

    // Galois form of x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        lfsr_next = s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    task automatic rand_byte(output logic [7:0] b);
        for (int i = 0; i < 8; i++) begin
            lfsr = lfsr_next(lfsr);
            b[i] = lfsr[0];
        end
        // The marker may only appear where it is placed on purpose
        if (b == `USB4_OS_MARK) begin
            b = b ^ 8'h01;
        end
    endtask

    // First block of a run is always an ordered set
    function automatic logic [1:0] blk_code(input case_t c, input int b);
        blk_code = (b == 0) ? H_OS : c.hdr_pat[2*b +: 2];
    endfunction

    function automatic logic [3:0] hdr_bits(input logic g3, input logic [1:0] code);
        case (code)
            H_OS:    hdr_bits = g3 ? G3_HDR_OS : {2'b00, G2_HDR_OS};
            H_DATA:  hdr_bits = g3 ? G3_HDR_DATA : {2'b00, G2_HDR_DATA};
            default: hdr_bits = g3 ? 4'b0110 : 4'b0011;
        endcase
    endfunction

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            err_cnt++;
            $display("[FAIL] %0t ns: %s, got 0x%0h, expected 0x%0h", $time, what, got, exp);
            $display("RESULT: FAIL");
            $fatal(1, "Stopping at the first mismatch");
        end
    endtask

    task automatic run_case(input case_t c);
        logic                   g3;
        int                     n;
        int                     hw;
        int                     s;
        int                     total;
        int                     j;
        int                     wait_cnt;
        logic                   os_now;
        logic [1:0]             code;
        logic [3:0]             hdr;
        logic [7:0]             b1;
        logic [7:0]             l0 [MAX_BYTES];
        logic [7:0]             l1 [MAX_BYTES];
        logic [`USB4_ENC_W-1:0] w0 [MAX_BLKS];
        logic [`USB4_ENC_W-1:0] w1 [MAX_BLKS];
        g3    = (c.speed == GEN3);
        n     = g3 ? `USB4_G3_BYTES : `USB4_G2_BYTES;
        hw    = g3 ? `USB4_G3_HDR_W : `USB4_G2_HDR_W;
        s     = c.skew;
        total = c.n_blocks * n;

        for (int i = 0; i < total; i++) begin
            rand_byte(l0[i]);
            rand_byte(l1[i]);
        end
        l0[0] = `USB4_OS_MARK;
        l1[0] = `USB4_OS_MARK;

        // Lane 1 runs s bytes late behind filler bytes
        for (int b = 0; b < c.n_blocks; b++) begin
            hdr   = hdr_bits(g3, blk_code(c, b));
            w0[b] = '0;
            w1[b] = '0;
            for (int h = 0; h < hw; h++) begin
                w0[b][h] = hdr[h];
                w1[b][h] = hdr[h];
            end
            for (int k = 0; k < n; k++) begin
                j = b * n + k;
                b1 = 8'h00;
                if (j >= s) begin
                    b1 = l1[j-s];
                end
                w0[b][hw + 8*k +: 8] = l0[j];
                w1[b][hw + 8*k +: 8] = b1;
            end
        end

        // Pairs start on the first lane-0 block boundary after lock
        os_now = 1'b0;
        for (int i = 0; i < total; i++) begin
            if (i % n == 0) begin
                code = blk_code(c, i / n);
                if (code == H_OS) begin
                    os_now = 1'b1;
                end else if (code == H_DATA) begin
                    os_now = 1'b0;
                end
            end
            if (c.exp_lock && (i >= n)) begin
                exp_0.push_back(l0[i]);
                exp_1.push_back(l1[i]);
                exp_1_chk.push_back(i + s < total);
                exp_os.push_back(os_now);
            end
        end

        saw_lock = 1'b0;
        saw_err  = 1'b0;
        pair_idx = 0;
        @(posedge enc_clk);
        gen_speed <= c.speed;
        repeat (2) @(posedge enc_clk);
        enable_dec    <= 1'b1;
        lane_0_rx_enc <= w0[0];
        lane_1_rx_enc <= w1[0];
        @(posedge enc_clk);
        // Each pass lands on the capture edge of block b
        for (int b = 0; b < c.n_blocks; b++) begin
            if (b > 0) begin
                repeat (n) @(posedge enc_clk);
            end
            if (b + 1 < c.n_blocks) begin
                lane_0_rx_enc <= w0[b+1];
                lane_1_rx_enc <= w1[b+1];
            end else begin
                enable_dec    <= 1'b0;
                lane_0_rx_enc <= '0;
                lane_1_rx_enc <= '0;
            end
        end

        wait_cnt = 0;
        while (((exp_0.size() != 0) || deskew_locked) && (wait_cnt < 80)) begin
            @(negedge enc_clk);
            wait_cnt++;
        end
        @(negedge enc_clk);
        check_value($sformatf("case %0d pairs missing", case_idx), exp_0.size(), 0);
        check_value($sformatf("case %0d lock released", case_idx), deskew_locked, 0);
        check_value($sformatf("case %0d lock seen", case_idx), saw_lock, c.exp_lock);
        check_value($sformatf("case %0d skew error seen", case_idx), saw_err, !c.exp_lock);
        repeat (20) @(posedge enc_clk);
    endtask

    always @(negedge enc_clk) begin : pair_monitor
        logic [7:0] e0;
        logic [7:0] e1;
        logic       e1_chk;
        logic       e_os;
        if (rst && deskew_locked) begin
            saw_lock = 1'b1;
        end
        if (rst && skew_error) begin
            saw_err = 1'b1;
        end
        if (rst && rx_valid) begin
            check_value($sformatf("case %0d pair %0d expected", case_idx, pair_idx),
                        exp_0.size() != 0, 1);
            e0     = exp_0.pop_front();
            e1     = exp_1.pop_front();
            e1_chk = exp_1_chk.pop_front();
            e_os   = exp_os.pop_front();
            check_value($sformatf("case %0d pair %0d lane 0", case_idx, pair_idx), rx_lane_0, e0);
            if (e1_chk) begin
                check_value($sformatf("case %0d pair %0d lane 1", case_idx, pair_idx),
                            rx_lane_1, e1);
            end
            check_value($sformatf("case %0d pair %0d rx_os", case_idx, pair_idx), rx_os, e_os);
            pair_idx++;
        end
    end

    initial begin : watchdog
        longint limit;
        case_t  row;
        limit = 2000;
        for (int i = 0; i < NUM_CASES; i++) begin
            row = case_row(i);
            limit += row.n_blocks * 16 * 20 + 3000;
        end
        #(limit);
        $display("Timeout: the run did not finish within %0d ns", limit);
        $display("RESULT: FAIL");
        $fatal(1, "Watchdog expired");
    end

    initial begin
        enc_clk       = 1'b0;
        lfsr          = 32'h336aaf73;
        err_cnt       = 0;
        case_idx      = 0;
        pair_idx      = 0;
        saw_lock      = 1'b0;
        saw_err       = 1'b0;
        rst           = 1'b0;
        enable_dec    = 1'b0;
        gen_speed     = GEN2;
        lane_0_rx_enc = '0;
        lane_1_rx_enc = '0;
        repeat (2) @(posedge enc_clk);
        rst <= 1'b1;

        // Outputs stay quiet with the decoder disabled
        repeat (10) begin
            @(negedge enc_clk);
            check_value("rx_valid while idle", rx_valid, 0);
            check_value("deskew_locked while idle", deskew_locked, 0);
            check_value("skew_error while idle", skew_error, 0);
            check_value("rx_os while idle", rx_os, 0);
        end

        for (int i = 0; i < NUM_CASES; i++) begin
            case_idx = i;
            run_case(case_row(i));
        end

        if (err_cnt == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- filelist.f
+incdir+hw
hw/usb4_lane_pkg.sv
hw/usb4_line_code_pkg.sv
hw/rx_lane_if.sv
hw/rx_block_decoder.sv
hw/lane_deskew.sv
hw/usb4_rx_top.sv
sim/tb_usb4_rx.sv

//--- Bender.yml
package:
  name: usb4_rx

sources:
  - include_dirs:
      - hw
    files:
      - hw/usb4_lane_pkg.sv
      - hw/usb4_line_code_pkg.sv
      - hw/rx_lane_if.sv
      - hw/rx_block_decoder.sv
      - hw/lane_deskew.sv
      - hw/usb4_rx_top.sv
  - target: simulation
    include_dirs:
      - hw
    files:
      - sim/tb_usb4_rx.sv
